// ==== filelist.f ====
logic/act_fmt_pkg.sv
logic/act_ctrl_pkg.sv
logic/gbuf_rd_if.sv
logic/act_gbuf.sv
logic/act_dispatch_ctrl.sv
logic/act_packer.sv
logic/act_dispatch_top.sv
sim/act_dispatch_tb.sv

// ==== Bender.yml ====
package:
  name: act_dispatch

sources:
  - target: any(rtl, simulation)
    files:
      - logic/act_fmt_pkg.sv
      - logic/act_ctrl_pkg.sv
      - logic/gbuf_rd_if.sv
      - logic/act_gbuf.sv
      - logic/act_dispatch_ctrl.sv
      - logic/act_packer.sv
      - logic/act_dispatch_top.sv

  - target: simulation
    files:
      - sim/act_dispatch_tb.sv

// ==== sim/act_dispatch_tb.sv ====
//==================================================
// Drives act_dispatch_top with the act_fmt_pkg defaults
// Model assumes packed data fits the buffer without wrap
//==================================================
`timescale 1ns/10ps

module act_dispatch_tb;

    import act_fmt_pkg::*;
    import act_ctrl_pkg::*;

    localparam int DATA_WIDTH  = DEF_DATA_WIDTH;
    localparam int BLOCK_DEPTH = DEF_BLOCK_DEPTH;
    localparam int FLAG_AW     = DEF_FLAG_AW;
    localparam int DATA_AW     = DEF_DATA_AW;
    localparam int DENSE_W     = DEF_DENSE_WIDTH;
    localparam int FLAG_DEPTH  = 1 << FLAG_AW;
    localparam int DATA_DEPTH  = 1 << DATA_AW;
    localparam int RST_CYCLES  = 10;

    //==================================================
    // Block layout and run length
    //==================================================
    // 0..19 random, 20 empty, 21 random, 22 full, 23..27 stalled
    localparam int RAND_N      = 20;
    localparam int ZERO_BLK    = 20;
    localparam int ONES_BLK    = 22;
    localparam int BP_BLK_N    = 5;
    localparam int NUM_BLOCKS  = 28;
    localparam int REPLAY_N    = 3;
    localparam int MAX_STALL   = 7;
    localparam int NUM_FETCHES = RAND_N + 2 + 1 + BP_BLK_N + REPLAY_N;
    localparam int LOAD_CYCLES = RST_CYCLES + NUM_BLOCKS * (BLOCK_DEPTH + 1) + 8;
    localparam int TIMEOUT_CYCLES = NUM_FETCHES * (BLOCK_DEPTH + 8 + MAX_STALL) + LOAD_CYCLES;

    logic                   clk = 1'b0;
    logic                   rst_n;
    logic                   wr_valid;
    buf_sel_e               wr_sel;
    logic [DATA_AW-1:0]     wr_addr;
    logic [BLOCK_DEPTH-1:0] wr_data;
    logic                   fetch_valid;
    logic                   fetch_ready;
    logic                   rewind;
    logic                   out_valid;
    logic                   out_ready;
    logic [DENSE_W-1:0]     out_act;
    logic [BLOCK_DEPTH-1:0] out_flag;

    // Mirror of the buffer contents and read pointers
    logic [BLOCK_DEPTH-1:0] flag_model [0:FLAG_DEPTH-1];
    logic [DATA_WIDTH-1:0]  data_model [0:DATA_DEPTH-1];
    // DUT vectors from the first pass over the replayed blocks
    logic [DENSE_W-1:0]     first_act  [0:REPLAY_N-1];
    int                     m_flag_ptr = 0;
    int                     m_data_ptr = 0;
    logic [31:0]            lfsr = 32'he2fe_86ee;
    int                     cycle_cnt = 0;
    int                     err_cnt = 0;
    int                     check_cnt = 0;
    int                     test_cnt = 0;
    int                     fail_cnt = 0;

    act_dispatch_top #(
        .DATA_WIDTH  (DATA_WIDTH),
        .BLOCK_DEPTH (BLOCK_DEPTH),
        .FLAG_AW     (FLAG_AW),
        .DATA_AW     (DATA_AW)
    ) u_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .wr_valid    (wr_valid),
        .wr_sel      (wr_sel),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .fetch_valid (fetch_valid),
        .fetch_ready (fetch_ready),
        .rewind      (rewind),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .out_act     (out_act),
        .out_flag    (out_flag)
    );

    always #5 clk = ~clk;

    // Watchdog on the total cycle budget
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: DUT did not complete the tests within %0d cycles",
                     TIMEOUT_CYCLES);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    //==================================================
    // Random source, compare and test bookkeeping
    //==================================================
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic compare_value(input string name, input logic [DENSE_W-1:0] exp_v,
                                 input logic [DENSE_W-1:0] act_v);
        check_cnt++;
        if (act_v !== exp_v) begin
            err_cnt++;
            $display("Mismatch %s: expected %h, actual %h", name, exp_v, act_v);
        end
    endtask

    task automatic end_test(input string name, input int err_before);
        test_cnt++;
        if (err_cnt != err_before) fail_cnt++;
        $display("Test %s done, %0d mismatches", name, err_cnt - err_before);
    endtask

    // Called after a clock edge so the write lands on the next one
    task automatic write_word(input buf_sel_e sel, input int addr,
                              input logic [BLOCK_DEPTH-1:0] data);
        wr_valid <= 1'b1;
        wr_sel   <= sel;
        wr_addr  <= DATA_AW'(addr);
        wr_data  <= data;
        @(posedge clk);
    endtask

    //==================================================
    // One fetch with expected vector from the model
    //==================================================
    // k-th packed value goes to the k-th set lane and the rest stay zero
    task automatic fetch_and_check(input string name, input int stall,
                                   output logic [DENSE_W-1:0] exp_act,
                                   output logic [DENSE_W-1:0] got_act);
        logic [BLOCK_DEPTH-1:0] exp_flag;
        logic [BLOCK_DEPTH-1:0] held_flag;
        int                     k;
        exp_flag = flag_model[m_flag_ptr];
        exp_act  = '0;
        k        = 0;
        for (int i = 0; i < BLOCK_DEPTH; i++) begin
            if (exp_flag[i]) begin
                exp_act[i*DATA_WIDTH +: DATA_WIDTH] = data_model[(m_data_ptr + k) % DATA_DEPTH];
                k++;
            end
        end
        m_flag_ptr = (m_flag_ptr + 1) % FLAG_DEPTH;
        m_data_ptr = (m_data_ptr + k) % DATA_DEPTH;
        // Fetch handshake
        fetch_valid <= 1'b1;
        @(posedge clk);
        while (!fetch_ready) @(posedge clk);
        fetch_valid <= 1'b0;
        @(posedge clk);
        while (!out_valid) @(posedge clk);
        got_act   = out_act;
        held_flag = out_flag;
        compare_value({name, " out_flag"}, exp_flag, held_flag);
        compare_value({name, " out_act"}, exp_act, got_act);
        // Output must hold through the consumer stall
        for (int s = 0; s < stall; s++) begin
            @(posedge clk);
            compare_value({name, " held out_valid"}, 1, out_valid);
            compare_value({name, " held out_act"}, got_act, out_act);
            compare_value({name, " held out_flag"}, held_flag, out_flag);
            compare_value({name, " stalled fetch_ready"}, 0, fetch_ready);
        end
        out_ready <= 1'b1;
        @(posedge clk);
        out_ready <= 1'b0;
        @(posedge clk);
        // Delivered once and back in IDLE
        compare_value({name, " out_valid after accept"}, 0, out_valid);
        compare_value({name, " fetch_ready after accept"}, 1, fetch_ready);
    endtask

    //==================================================
    // Main sequence
    //==================================================
    initial begin
        logic [31:0]            r;
        logic [BLOCK_DEPTH-1:0] f;
        logic [DENSE_W-1:0]     exp_v;
        logic [DENSE_W-1:0]     got_v;
        int                     daddr;
        int                     err_before;
        rst_n       = 1'b0;
        wr_valid    = 1'b0;
        wr_sel      = SEL_FLAG;
        wr_addr     = '0;
        wr_data     = '0;
        fetch_valid = 1'b0;
        rewind      = 1'b0;
        out_ready   = 1'b0;

        // Block contents with packed data back to back
        daddr = 0;
        for (int b = 0; b < NUM_BLOCKS; b++) begin
            if (b == ZERO_BLK) begin
                f = '0;
            end else if (b == ONES_BLK) begin
                f = '1;
            end else begin
                draw_bits(BLOCK_DEPTH, r);
                f = r[BLOCK_DEPTH-1:0];
            end
            flag_model[b] = f;
            for (int i = 0; i < BLOCK_DEPTH; i++) begin
                if (f[i]) begin
                    draw_bits(DATA_WIDTH, r);
                    data_model[daddr] = r[DATA_WIDTH-1:0];
                    daddr++;
                end
            end
        end

        repeat (RST_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        @(posedge clk);
        compare_value("reset fetch_ready", 1, fetch_ready);
        compare_value("reset out_valid", 0, out_valid);

        // Buffer load with random noise in the unused data bits
        for (int b = 0; b < NUM_BLOCKS; b++) begin
            write_word(SEL_FLAG, b, flag_model[b]);
        end
        for (int a = 0; a < daddr; a++) begin
            draw_bits(BLOCK_DEPTH - DATA_WIDTH, r);
            write_word(SEL_DATA, a, {r[BLOCK_DEPTH-DATA_WIDTH-1:0], data_model[a]});
        end
        wr_valid <= 1'b0;
        @(posedge clk);

        err_before = err_cnt;
        for (int b = 0; b < RAND_N; b++) begin
            fetch_and_check($sformatf("random block %0d", b), 0, exp_v, got_v);
            if (b < REPLAY_N) first_act[b] = got_v;
        end
        end_test("random sparse blocks", err_before);

        // Following block proves nothing was consumed
        err_before = err_cnt;
        fetch_and_check("zero flag block", 0, exp_v, got_v);
        fetch_and_check("block after zero flag", 0, exp_v, got_v);
        end_test("all-zero flag", err_before);

        err_before = err_cnt;
        fetch_and_check("ones flag block", 0, exp_v, got_v);
        end_test("all-ones flag", err_before);

        err_before = err_cnt;
        for (int b = 0; b < BP_BLK_N; b++) begin
            draw_bits(3, r);
            fetch_and_check($sformatf("stall %0d block %0d", r[2:0], b), r[2:0], exp_v, got_v);
        end
        end_test("back-pressure", err_before);

        // Rewind pulse in IDLE replays from block 0
        err_before = err_cnt;
        rewind <= 1'b1;
        @(posedge clk);
        rewind <= 1'b0;
        m_flag_ptr = 0;
        m_data_ptr = 0;
        for (int b = 0; b < REPLAY_N; b++) begin
            fetch_and_check($sformatf("replay block %0d", b), 0, exp_v, got_v);
            compare_value($sformatf("replay vs first block %0d", b), first_act[b], got_v);
        end
        end_test("rewind replay", err_before);

        $display("Tests %0d, failed tests %0d, checks %0d, mismatches %0d",
                 test_cnt, fail_cnt, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== logic/act_dispatch_top.sv ====
//==================================================
// Activation dispatch top, buffers loaded via wr port
// Requires FLAG_AW <= DATA_AW, wr_addr is DATA_AW wide
//==================================================
`timescale 1ns/10ps

module act_dispatch_top #(
    parameter int DATA_WIDTH  = act_fmt_pkg::DEF_DATA_WIDTH,
    parameter int BLOCK_DEPTH = act_fmt_pkg::DEF_BLOCK_DEPTH,
    parameter int FLAG_AW     = act_fmt_pkg::DEF_FLAG_AW,
    parameter int DATA_AW     = act_fmt_pkg::DEF_DATA_AW
) (
    input  logic                              clk,
    input  logic                              rst_n,
    // Buffer load, data writes use the low DATA_WIDTH bits
    input  logic                              wr_valid,
    input  act_ctrl_pkg::buf_sel_e            wr_sel,
    input  logic [DATA_AW-1:0]                wr_addr,
    input  logic [BLOCK_DEPTH-1:0]            wr_data,
    // Fetch request
    input  logic                              fetch_valid,
    output logic                              fetch_ready,
    input  logic                              rewind,
    // Dense block out
    output logic                              out_valid,
    input  logic                              out_ready,
    output logic [BLOCK_DEPTH*DATA_WIDTH-1:0] out_act,
    output logic [BLOCK_DEPTH-1:0]            out_flag
);

    import act_ctrl_pkg::*;

    logic               flag_wr_en;
    logic               data_wr_en;
    logic [FLAG_AW-1:0] flag_wr_addr;
    logic               pack_start;
    logic               pack_req;
    logic               pack_done;

    gbuf_rd_if #(.ADDR_WIDTH(FLAG_AW), .DATA_WIDTH(BLOCK_DEPTH)) flag_rd ();
    gbuf_rd_if #(.ADDR_WIDTH(DATA_AW), .DATA_WIDTH(DATA_WIDTH))  data_rd ();

    //==================================================
    // Global buffers
    //==================================================
    assign flag_wr_en   = wr_valid && (wr_sel == SEL_FLAG);
    assign data_wr_en   = wr_valid && (wr_sel == SEL_DATA);
    assign flag_wr_addr = wr_addr[FLAG_AW-1:0];

    act_gbuf #(.ADDR_WIDTH(FLAG_AW), .DATA_WIDTH(BLOCK_DEPTH)) u_flag_buf (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_en   (flag_wr_en),
        .wr_addr (flag_wr_addr),
        .wr_data (wr_data),
        .rd      (flag_rd)
    );

    act_gbuf #(.ADDR_WIDTH(DATA_AW), .DATA_WIDTH(DATA_WIDTH)) u_data_buf (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_en   (data_wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data[DATA_WIDTH-1:0]),
        .rd      (data_rd)
    );

    //==================================================
    // Controller and packer
    //==================================================
    // FSM walks IDLE, READ_FLAG, PACK, HOLD per block
    act_dispatch_ctrl #(
        .BLOCK_DEPTH (BLOCK_DEPTH),
        .FLAG_AW     (FLAG_AW),
        .DATA_AW     (DATA_AW)
    ) u_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .fetch_valid (fetch_valid),
        .fetch_ready (fetch_ready),
        .rewind      (rewind),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .out_flag    (out_flag),
        .flag_rd     (flag_rd),
        .data_rd     (data_rd),
        .pack_start  (pack_start),
        .pack_req    (pack_req),
        .pack_done   (pack_done)
    );

    // Captured flag doubles as the packer lane map
    act_packer #(
        .DATA_WIDTH  (DATA_WIDTH),
        .BLOCK_DEPTH (BLOCK_DEPTH)
    ) u_packer (
        .clk        (clk),
        .rst_n      (rst_n),
        .pack_start (pack_start),
        .flag       (out_flag),
        .pack_req   (pack_req),
        .data_rd    (data_rd),
        .pack_done  (pack_done),
        .act_dense  (out_act)
    );

endmodule

// ==== logic/act_packer.sv ====
//==================================================
// Sparse to dense expander, k-th value to k-th set lane
// Expects exactly popcount(flag) returns per block
//==================================================
`timescale 1ns/10ps

module act_packer #(
    parameter int DATA_WIDTH  = act_fmt_pkg::DEF_DATA_WIDTH,
    parameter int BLOCK_DEPTH = act_fmt_pkg::DEF_BLOCK_DEPTH
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              pack_start,
    input  logic [BLOCK_DEPTH-1:0]            flag,
    output logic                              pack_req,
    gbuf_rd_if.consumer                       data_rd,
    output logic                              pack_done,
    output logic [BLOCK_DEPTH*DATA_WIDTH-1:0] act_dense
);

    localparam int CNT_W = $clog2(BLOCK_DEPTH + 1);

    logic [CNT_W-1:0]       flag_ones;
    logic [CNT_W-1:0]       req_left;
    logic [BLOCK_DEPTH-1:0] lane_mask;
    logic [BLOCK_DEPTH-1:0] lane_next;
    logic [BLOCK_DEPTH-1:0] lane_hit;
    logic                   last_val;

    //==================================================
    // Request burst
    //==================================================
    // Popcount of the incoming flag
    always_comb begin
        flag_ones = '0;
        for (int i = 0; i < BLOCK_DEPTH; i++) begin
            flag_ones = flag_ones + CNT_W'(flag[i]);
        end
    end

    // Back-to-back requests, one per set lane
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_left <= '0;
        end else if (pack_start) begin
            req_left <= flag_ones;
        end else if (pack_req) begin
            req_left <= req_left - CNT_W'(1);
        end
    end

    assign pack_req = (req_left != '0);

    //==================================================
    // Lane tracking
    //==================================================
    // Lowest remaining set lane takes the next return
    assign lane_hit  = lane_mask & (~lane_mask + BLOCK_DEPTH'(1));
    assign lane_next = lane_mask & ~lane_hit;
    // Only one lane left means this return finishes the block
    assign last_val  = data_rd.val && (lane_next == '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lane_mask <= '0;
            pack_done <= 1'b0;
        end else begin
            if (pack_start) begin
                lane_mask <= flag;
            end else if (data_rd.val) begin
                lane_mask <= lane_next;
            end
            // Empty block finishes right after start
            pack_done <= (pack_start && (flag == '0)) || last_val;
        end
    end

    //==================================================
    // Dense vector, lane 0 in the low bits
    //==================================================
    always_ff @(posedge clk) begin
        if (pack_start) begin
            act_dense <= '0;
        end else if (data_rd.val) begin
            for (int i = 0; i < BLOCK_DEPTH; i++) begin
                if (lane_hit[i]) act_dense[i*DATA_WIDTH +: DATA_WIDTH] <= data_rd.data;
            end
        end
    end

endmodule

// ==== logic/act_dispatch_ctrl.sv ====
//==================================================
// Dispatch FSM and read pointers, rewind only in IDLE
// Pointers wrap silently at the end of each buffer
//==================================================
`timescale 1ns/10ps

module act_dispatch_ctrl #(
    parameter int BLOCK_DEPTH = act_fmt_pkg::DEF_BLOCK_DEPTH,
    parameter int FLAG_AW     = act_fmt_pkg::DEF_FLAG_AW,
    parameter int DATA_AW     = act_fmt_pkg::DEF_DATA_AW
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   fetch_valid,
    output logic                   fetch_ready,
    input  logic                   rewind,
    output logic                   out_valid,
    input  logic                   out_ready,
    output logic [BLOCK_DEPTH-1:0] out_flag,
    gbuf_rd_if.master              flag_rd,
    gbuf_rd_if.addresser           data_rd,
    output logic                   pack_start,
    input  logic                   pack_req,
    input  logic                   pack_done
);

    import act_ctrl_pkg::*;

    dispatch_state_e state;
    dispatch_state_e state_nxt;

    logic               fetch_hs;
    logic               flag_en;
    logic [FLAG_AW-1:0] flag_ptr;
    logic [DATA_AW-1:0] data_ptr;

    //==================================================
    // Handshakes and FSM
    //==================================================
    assign fetch_ready = (state == IDLE);
    assign fetch_hs    = fetch_valid && fetch_ready;
    assign out_valid   = (state == HOLD);

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:      if (fetch_hs)    state_nxt = READ_FLAG;
            // Wait out the buffer read latency
            READ_FLAG: if (flag_rd.val) state_nxt = PACK;
            PACK:      if (pack_done)   state_nxt = HOLD;
            HOLD:      if (out_ready)   state_nxt = IDLE;
            default:                    state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= IDLE;
            flag_en    <= 1'b0;
            pack_start <= 1'b0;
        end else begin
            state      <= state_nxt;
            // Single flag read in the first READ_FLAG cycle
            flag_en    <= fetch_hs;
            // Packer kicks off together with the captured flag
            pack_start <= (state == READ_FLAG) && flag_rd.val;
        end
    end

    //==================================================
    // Read pointers
    //==================================================
    // Rewind wins over the increment, and reads never run in IDLE
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            flag_ptr <= '0;
            data_ptr <= '0;
        end else begin
            if (rewind && (state == IDLE)) begin
                flag_ptr <= '0;
                data_ptr <= '0;
            end else begin
                if (flag_en) flag_ptr <= flag_ptr + FLAG_AW'(1);
                if (pack_req) data_ptr <= data_ptr + DATA_AW'(1);
            end
        end
    end

    assign flag_rd.en   = flag_en;
    assign flag_rd.addr = flag_ptr;

    // One packed word per packer request
    assign data_rd.en   = pack_req;
    assign data_rd.addr = data_ptr;

    // Flag capture, steady through HOLD
    always_ff @(posedge clk) begin
        if ((state == READ_FLAG) && flag_rd.val) begin
            out_flag <= flag_rd.data;
        end
    end

endmodule

// ==== logic/act_gbuf.sv ====
//==================================================
// Simple dual-port buffer, read-old on addr collision
// Contents undefined after reset until written
//==================================================
`timescale 1ns/10ps

module act_gbuf #(
    parameter int ADDR_WIDTH = 10,
    parameter int DATA_WIDTH = 8
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  wr_en,
    input  logic [ADDR_WIDTH-1:0] wr_addr,
    input  logic [DATA_WIDTH-1:0] wr_data,
    gbuf_rd_if.mem                rd
);

    localparam int DEPTH = 1 << ADDR_WIDTH;

    logic [DATA_WIDTH-1:0] mem [0:DEPTH-1];

    //==================================================
    // Storage, write and registered read
    //==================================================
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
        // Read data lands with val
        if (rd.en) begin
            rd.data <= mem[rd.addr];
        end
    end

    // Return strobe, one cycle behind the request
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd.val <= 1'b0;
        end else begin
            rd.val <= rd.en;
        end
    end

endmodule

// ==== logic/gbuf_rd_if.sv ====
//==================================================
// Global buffer read port, val follows en by 1 cycle
// No back-pressure, every request returns data
//==================================================
`timescale 1ns/10ps

interface gbuf_rd_if #(
    parameter int ADDR_WIDTH = 10,
    parameter int DATA_WIDTH = 8
);

    // Request side
    logic                  en;
    logic [ADDR_WIDTH-1:0] addr;

    // Return side
    logic                  val;
    logic [DATA_WIDTH-1:0] data;

    // Buffer itself
    modport mem (input en, input addr, output val, output data);

    // Requester that also consumes the return
    modport master (output en, output addr, input val, input data);

    // Requester only, return goes elsewhere
    modport addresser (output en, output addr);

    // Return only, requests come from elsewhere
    modport consumer (input val, input data);

endinterface

// ==== logic/act_ctrl_pkg.sv ====
//==================================================
// Control encodings for the activation dispatcher
//==================================================
package act_ctrl_pkg;

    // Dispatcher FSM
    // IDLE accepts a fetch, HOLD waits for the consumer
    typedef enum logic [1:0] {
        IDLE      = 2'b00,
        READ_FLAG = 2'b01,
        PACK      = 2'b11,
        HOLD      = 2'b10
    } dispatch_state_e;

    // Write port target buffer
    typedef enum logic {
        SEL_FLAG = 1'b0,
        SEL_DATA = 1'b1
    } buf_sel_e;

endpackage

// ==== logic/act_fmt_pkg.sv ====
//==================================================
// Default activation format, overridden at top level
// FLAG_AW must not exceed DATA_AW (shared write addr)
//==================================================
package act_fmt_pkg;

    // Width of one packed activation value
    parameter int DEF_DATA_WIDTH  = 8;

    // Lanes per compressed block, also the flag width
    parameter int DEF_BLOCK_DEPTH = 16;

    // Flag buffer depth is 2**DEF_FLAG_AW blocks
    parameter int DEF_FLAG_AW     = 6;

    // Packed value buffer depth is 2**DEF_DATA_AW words
    parameter int DEF_DATA_AW     = 10;

    //==================================================
    // Derived sizes
    //==================================================
    // Dense output vector width
    parameter int DEF_DENSE_WIDTH = DEF_DATA_WIDTH * DEF_BLOCK_DEPTH;

endpackage
